// ==== source/rob_cfg_pkg.sv ====
// Default sizing of the reorder buffer and the typedefs built on it.
// rob_top takes its parameter defaults from here; the testbench uses the
// typedefs for its reference model and compare tasks.
package rob_cfg_pkg;

	// one bank per lane of the four-wide bundle
	localparam int NBANK = 4;

	localparam int DEF_WIDTH_ROW = 3; // log2 of row count
	localparam int DEF_WIDTH_REG = 7;
	localparam int DEF_WIDTH_BRM = 4; // one bit per branch in flight

	typedef logic [DEF_WIDTH_ROW-1:0] row_t;
	typedef logic [DEF_WIDTH_REG-1:0] prd_t;
	typedef logic [DEF_WIDTH_BRM-1:0] brmask_t;

	// word aligned so the low two bits stay zero
	typedef logic [31:0] pc_t;

	typedef logic [1:0] lane_t;

endpackage

// ==== source/rob_uop_pkg.sv ====
// Micro-op opcodes and slot states of the reorder buffer.
// Imported by the dispatch, bank and commit stages and by the testbench.
package rob_uop_pkg;

	typedef enum logic [2:0] {
		OP_NOP    = 3'd0,
		OP_ALU    = 3'd1,
		OP_LOAD   = 3'd2,
		OP_STORE  = 3'd3,
		OP_BRANCH = 3'd4
	} uop_op_e;

	// free slots are empty or squashed and never commit
	typedef enum logic [1:0] {
		SLOT_FREE = 2'd0,
		SLOT_WAIT = 2'd1,
		SLOT_DONE = 2'd2
	} slot_state_e;

endpackage

// ==== source/rob_dispatch.sv ====
// First stage of the reorder buffer. Registers a dispatched bundle and
// turns valid bits and opcodes into the initial state of each slot.
// The registered bundle is written into the tail row one edge later.
`timescale 1ns/1ps

module rob_dispatch #(
	parameter int WIDTH_REG = rob_cfg_pkg::DEF_WIDTH_REG,
	parameter int WIDTH_BRM = rob_cfg_pkg::DEF_WIDTH_BRM
) (
	input  logic                                              i_clk,
	input  logic                                              i_rst_n,
	input  logic                                              i_dis_we,
	input  rob_cfg_pkg::pc_t                                  i_dis_pc,
	input  logic [rob_cfg_pkg::NBANK-1:0]                     i_dis_val,
	input  rob_uop_pkg::uop_op_e [rob_cfg_pkg::NBANK-1:0]     i_dis_op,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_REG-1:0]           i_dis_prd4x,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_BRM-1:0]           i_dis_brmask4x,
	input  logic                                              i_full,
	output logic                                              o_we,
	output rob_cfg_pkg::pc_t                                  o_pc,
	output rob_uop_pkg::slot_state_e [rob_cfg_pkg::NBANK-1:0] o_state4x,
	output logic [rob_cfg_pkg::NBANK*WIDTH_REG-1:0]           o_prd4x,
	output logic [rob_cfg_pkg::NBANK*WIDTH_BRM-1:0]           o_brmask4x
);
	import rob_cfg_pkg::*;
	import rob_uop_pkg::*;

	slot_state_e [NBANK-1:0] init_state;
	logic                    accept;
	logic                    op_legal;

	assign accept = i_dis_we & ~i_full; // bundle is lost when full

	always_comb begin
		op_legal = 1'b1;
		for (int l = 0; l < NBANK; l++) begin
			if (!i_dis_val[l])
				init_state[l] = SLOT_FREE;
			else if (i_dis_op[l] == OP_NOP)
				init_state[l] = SLOT_DONE; // no unit will report it
			else
				init_state[l] = SLOT_WAIT;
			if (i_dis_val[l] && !(i_dis_op[l] inside {OP_NOP, OP_ALU, OP_LOAD,
				OP_STORE, OP_BRANCH}))
				op_legal = 1'b0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_we <= 1'b0;
		else
			o_we <= accept;
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_pc       <= i_dis_pc;
			o_state4x  <= init_state;
			o_prd4x    <= i_dis_prd4x;
			o_brmask4x <= i_dis_brmask4x;
		end
	end

	// full comes from the pointer ring and the renamer has to respect it
	a_dis_not_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dis_we |-> !i_full)
		else $error("dispatch while reorder buffer is full, bundle dropped");

	a_op_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dis_we |-> op_legal)
		else $error("valid slot with an undefined opcode in dispatched bundle");

endmodule

// ==== source/rob_ring_ptr.sv ====
// Head and tail pointers of the reorder buffer, kept as one-hot rings,
// with the per-row pc store, occupancy count, empty and full.
// o_dis_tag holds the row index of the last written bundle.
`timescale 1ns/1ps

module rob_ring_ptr #(
	parameter int WIDTH_ROW = rob_cfg_pkg::DEF_WIDTH_ROW
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_we,
	input  rob_cfg_pkg::pc_t        i_pc,
	input  logic                    i_re,
	output logic [2**WIDTH_ROW-1:0] o_head,
	output logic [2**WIDTH_ROW-1:0] o_tail,
	output rob_cfg_pkg::pc_t        o_head_pc,
	output logic                    o_empty,
	output logic                    o_full,
	output logic [WIDTH_ROW-1:0]    o_dis_tag
);
	import rob_cfg_pkg::*;

	localparam int SIZE = 2**WIDTH_ROW;

	pc_t                  pc_mem [SIZE];
	logic [WIDTH_ROW:0]   count;
	logic [WIDTH_ROW-1:0] tail_idx;

	assign o_empty = (count == '0);
	assign o_full  = (count == SIZE[WIDTH_ROW:0]);

	always_comb begin
		tail_idx  = '0;
		o_head_pc = '0;
		for (int r = 0; r < SIZE; r++) begin
			if (o_tail[r])
				tail_idx = tail_idx | WIDTH_ROW'(r); // one-hot to index
			if (o_head[r])
				o_head_pc = pc_mem[r];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_head    <= SIZE'(1);
			o_tail    <= SIZE'(1);
			count     <= '0;
			o_dis_tag <= '0;
		end else begin
			if (i_we) begin
				o_tail    <= {o_tail[SIZE-2:0], o_tail[SIZE-1]};
				o_dis_tag <= tail_idx;
			end
			if (i_re)
				o_head <= {o_head[SIZE-2:0], o_head[SIZE-1]};
			if (i_we && !i_re)
				count <= count + 1'b1;
			else if (i_re && !i_we)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		for (int r = 0; r < SIZE; r++)
			if (i_we && o_tail[r])
				pc_mem[r] <= i_pc;
	end

	a_ptr_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot(o_head) && $onehot(o_tail))
		else $error("head or tail pointer lost its one-hot form");

endmodule

// ==== source/rob_slot_bank.sv ====
// One bank of the reorder buffer, holding the slot of lane BANK_ID in
// every row. Writes the tail slot on dispatch, marks slots done from the
// four writeback ports and squashes slots on a branch kill.
`timescale 1ns/1ps

module rob_slot_bank #(
	parameter int BANK_ID   = 0,
	parameter int WIDTH_ROW = rob_cfg_pkg::DEF_WIDTH_ROW,
	parameter int WIDTH_REG = rob_cfg_pkg::DEF_WIDTH_REG,
	parameter int WIDTH_BRM = rob_cfg_pkg::DEF_WIDTH_BRM
) (
	input  logic                                            i_clk,
	input  logic                                            i_rst_n,
	input  logic                                            i_we,
	input  logic [2**WIDTH_ROW-1:0]                         i_tail,
	input  logic [2**WIDTH_ROW-1:0]                         i_head,
	input  rob_uop_pkg::slot_state_e                        i_state,
	input  logic [WIDTH_REG-1:0]                            i_prd,
	input  logic [WIDTH_BRM-1:0]                            i_brmask,
	input  logic [rob_cfg_pkg::NBANK-1:0]                   i_wb_en,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_ROW-1:0]         i_wb_row4x,
	input  rob_cfg_pkg::lane_t [rob_cfg_pkg::NBANK-1:0]     i_wb_bank4x,
	input  logic                                            i_kill_en,
	input  logic [$clog2(WIDTH_BRM)-1:0]                    i_kill_bit,
	output rob_uop_pkg::slot_state_e                        o_head_state,
	output logic [WIDTH_REG-1:0]                            o_head_prd
);
	import rob_cfg_pkg::*;
	import rob_uop_pkg::*;

	localparam int SIZE = 2**WIDTH_ROW;

	slot_state_e          state  [SIZE];
	logic [WIDTH_REG-1:0] prd    [SIZE];
	logic [WIDTH_BRM-1:0] brmask [SIZE];

	logic [SIZE-1:0] wb_hit;
	logic [SIZE-1:0] kill_hit;
	logic [SIZE-1:0] wb_free;
	logic            kill_new;

	// writeback decode of the ports naming this bank
	always_comb begin
		wb_hit = '0;
		for (int p = 0; p < NBANK; p++)
			if (i_wb_en[p] && i_wb_bank4x[p] == lane_t'(BANK_ID))
				wb_hit[i_wb_row4x[p*WIDTH_ROW +: WIDTH_ROW]] = 1'b1;
	end

	always_comb begin
		for (int r = 0; r < SIZE; r++) begin
			kill_hit[r] = i_kill_en & brmask[r][i_kill_bit];
			wb_free[r]  = wb_hit[r] & (state[r] == SLOT_FREE);
		end
	end

	assign kill_new = i_kill_en & i_brmask[i_kill_bit]; // slot arriving this edge

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int r = 0; r < SIZE; r++)
				state[r] <= SLOT_FREE;
		end else begin
			for (int r = 0; r < SIZE; r++) begin
				if (i_we && i_tail[r])
					state[r] <= kill_new ? SLOT_FREE : i_state;
				else if (kill_hit[r])
					state[r] <= SLOT_FREE; // squashed slot drains without commit
				else if (wb_hit[r] && state[r] == SLOT_WAIT)
					state[r] <= SLOT_DONE;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		for (int r = 0; r < SIZE; r++) begin
			if (i_we && i_tail[r]) begin
				prd[r]    <= i_prd;
				brmask[r] <= i_brmask;
			end
		end
	end

	always_comb begin
		o_head_state = SLOT_FREE;
		o_head_prd   = '0;
		for (int r = 0; r < SIZE; r++) begin
			if (i_head[r]) begin
				o_head_state = state[r];
				o_head_prd   = prd[r];
			end
		end
	end

	// execution units must only report slots that are still live
	a_wb_live: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		~|wb_free)
		else $error("bank %0d: writeback to a free slot", BANK_ID);

endmodule

// ==== source/rob_commit.sv ====
// Last stage of the reorder buffer. Retires the head row once no slot
// waits any more, advances the head and presents the row for one cycle
// on the commit outputs with a mask of the slots that really commit.
`timescale 1ns/1ps

module rob_commit #(
	parameter int WIDTH_REG = rob_cfg_pkg::DEF_WIDTH_REG
) (
	input  logic                                              i_clk,
	input  logic                                              i_rst_n,
	input  logic                                              i_empty,
	input  rob_uop_pkg::slot_state_e [rob_cfg_pkg::NBANK-1:0] i_head_state4x,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_REG-1:0]           i_head_prd4x,
	input  rob_cfg_pkg::pc_t                                  i_head_pc,
	output logic                                              o_re,
	output logic                                              o_com_en,
	output rob_cfg_pkg::pc_t                                  o_com_pc,
	output logic [rob_cfg_pkg::NBANK*WIDTH_REG-1:0]           o_com_prd4x,
	output logic [rob_cfg_pkg::NBANK-1:0]                     o_com_mask
);
	import rob_cfg_pkg::*;
	import rob_uop_pkg::*;

	logic             any_wait;
	logic [NBANK-1:0] live;

	always_comb begin
		any_wait = 1'b0;
		for (int l = 0; l < NBANK; l++) begin
			any_wait = any_wait | (i_head_state4x[l] == SLOT_WAIT);
			live[l]  = (i_head_state4x[l] != SLOT_FREE); // done or nop
		end
	end

	assign o_re = ~i_empty & ~any_wait;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_com_en <= 1'b0;
		else
			o_com_en <= o_re;
	end

	always_ff @(posedge i_clk) begin
		if (o_re) begin
			o_com_pc    <= i_head_pc;
			o_com_prd4x <= i_head_prd4x;
			o_com_mask  <= live;
		end
	end

endmodule

// ==== source/rob_top.sv ====
// Reorder buffer top level. Dispatch stage feeds the pointer ring and
// four slot banks, one per bundle lane; the commit stage retires the
// head row. Widths are set here and passed down to every stage.
`timescale 1ns/1ps

module rob_top #(
	parameter int WIDTH_ROW = rob_cfg_pkg::DEF_WIDTH_ROW,
	parameter int WIDTH_REG = rob_cfg_pkg::DEF_WIDTH_REG,
	parameter int WIDTH_BRM = rob_cfg_pkg::DEF_WIDTH_BRM
) (
	input  logic                                          i_clk,
	input  logic                                          i_rst_n,
	input  logic                                          i_dis_we,
	input  rob_cfg_pkg::pc_t                              i_dis_pc,
	input  logic [rob_cfg_pkg::NBANK-1:0]                 i_dis_val,
	input  rob_uop_pkg::uop_op_e [rob_cfg_pkg::NBANK-1:0] i_dis_op,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_REG-1:0]       i_dis_prd4x,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_BRM-1:0]       i_dis_brmask4x,
	input  logic [rob_cfg_pkg::NBANK-1:0]                 i_wb_en,
	input  logic [rob_cfg_pkg::NBANK*WIDTH_ROW-1:0]       i_wb_row4x,
	input  rob_cfg_pkg::lane_t [rob_cfg_pkg::NBANK-1:0]   i_wb_bank4x,
	input  logic                                          i_kill_en,
	input  logic [$clog2(WIDTH_BRM)-1:0]                  i_kill_bit,
	output logic [WIDTH_ROW-1:0]                          o_dis_tag,
	output logic                                          o_full,
	output logic                                          o_com_en,
	output rob_cfg_pkg::pc_t                              o_com_pc,
	output logic [rob_cfg_pkg::NBANK*WIDTH_REG-1:0]       o_com_prd4x,
	output logic [rob_cfg_pkg::NBANK-1:0]                 o_com_mask
);
	import rob_cfg_pkg::*;
	import rob_uop_pkg::*;

	localparam int SIZE = 2**WIDTH_ROW;

	wire                         dis_we;
	wire pc_t                    dis_pc;
	wire slot_state_e [NBANK-1:0] dis_state4x;
	wire [NBANK*WIDTH_REG-1:0]   dis_prd4x;
	wire [NBANK*WIDTH_BRM-1:0]   dis_brmask4x;
	wire [SIZE-1:0]              head;
	wire [SIZE-1:0]              tail;
	wire pc_t                    head_pc;
	wire                         empty;
	wire                         re;
	wire slot_state_e [NBANK-1:0] head_state4x;
	wire [NBANK*WIDTH_REG-1:0]   head_prd4x;

	rob_dispatch #(.WIDTH_REG(WIDTH_REG), .WIDTH_BRM(WIDTH_BRM)) u_dispatch (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_dis_we(i_dis_we), .i_dis_pc(i_dis_pc), .i_dis_val(i_dis_val),
		.i_dis_op(i_dis_op), .i_dis_prd4x(i_dis_prd4x),
		.i_dis_brmask4x(i_dis_brmask4x), .i_full(o_full),
		.o_we(dis_we), .o_pc(dis_pc), .o_state4x(dis_state4x),
		.o_prd4x(dis_prd4x), .o_brmask4x(dis_brmask4x)
	);

	rob_ring_ptr #(.WIDTH_ROW(WIDTH_ROW)) u_ring (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(dis_we), .i_pc(dis_pc), .i_re(re),
		.o_head(head), .o_tail(tail), .o_head_pc(head_pc),
		.o_empty(empty), .o_full(o_full), .o_dis_tag(o_dis_tag)
	);

	for (genvar b = 0; b < NBANK; b++) begin : g_bank
		rob_slot_bank #(
			.BANK_ID(b), .WIDTH_ROW(WIDTH_ROW),
			.WIDTH_REG(WIDTH_REG), .WIDTH_BRM(WIDTH_BRM)
		) u_bank (
			.i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(dis_we),
			.i_tail(tail), .i_head(head), .i_state(dis_state4x[b]),
			.i_prd(dis_prd4x[b*WIDTH_REG +: WIDTH_REG]),
			.i_brmask(dis_brmask4x[b*WIDTH_BRM +: WIDTH_BRM]),
			.i_wb_en(i_wb_en), .i_wb_row4x(i_wb_row4x), .i_wb_bank4x(i_wb_bank4x),
			.i_kill_en(i_kill_en), .i_kill_bit(i_kill_bit),
			.o_head_state(head_state4x[b]),
			.o_head_prd(head_prd4x[b*WIDTH_REG +: WIDTH_REG])
		);
	end

	rob_commit #(.WIDTH_REG(WIDTH_REG)) u_commit (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_empty(empty),
		.i_head_state4x(head_state4x), .i_head_prd4x(head_prd4x),
		.i_head_pc(head_pc), .o_re(re), .o_com_en(o_com_en),
		.o_com_pc(o_com_pc), .o_com_prd4x(o_com_prd4x), .o_com_mask(o_com_mask)
	);

endmodule

// ==== tb/rob_tb_clk.sv ====
// Clock and reset source for the reorder buffer testbench.
// Free-running clock, reset held low for a fixed number of cycles.
`timescale 1ns/1ps

module rob_tb_clk #(
	parameter real PERIOD_NS  = 4.0,
	parameter int  RST_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rst_n
);
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1; // release away from the edge
	end

endmodule

// ==== tb/rob_tb.sv ====
// Directed testbench for the reorder buffer. A reference model keeps one
// entry per row and the order of dispatch; a monitor checks every commit
// against the oldest outstanding row.
`timescale 1ns/1ps

module rob_tb;
	import rob_cfg_pkg::*;
	import rob_uop_pkg::*;

	localparam int WREG  = DEF_WIDTH_REG;
	localparam int WBRM  = DEF_WIDTH_BRM;
	localparam int WROW  = DEF_WIDTH_ROW;
	localparam int SIZE  = 2**WROW;
	localparam int LIMIT = 400; // cycles allowed for one wait

	logic                   clk;
	logic                   rst_n;
	logic                   dis_we;
	pc_t                    dis_pc;
	logic [NBANK-1:0]       dis_val;
	uop_op_e [NBANK-1:0]    dis_op;
	logic [NBANK*WREG-1:0]  dis_prd4x;
	logic [NBANK*WBRM-1:0]  dis_brmask4x;
	logic [NBANK-1:0]       wb_en;
	logic [NBANK*WROW-1:0]  wb_row4x;
	lane_t [NBANK-1:0]      wb_bank4x;
	logic                   kill_en;
	logic [$clog2(WBRM)-1:0] kill_bit;
	row_t                   dis_tag;
	logic                   full;
	logic                   com_en;
	pc_t                    com_pc;
	logic [NBANK*WREG-1:0]  com_prd4x;
	logic [NBANK-1:0]       com_mask;

	// reference model indexed by row
	pc_t                   m_pc   [SIZE];
	logic [NBANK*WREG-1:0] m_prd  [SIZE];
	logic [NBANK*WBRM-1:0] m_brm  [SIZE];
	logic [NBANK-1:0]      m_mask [SIZE];
	logic [NBANK-1:0]      m_wait [SIZE]; // slots still owed a writeback
	row_t                  order_q [$];
	row_t                  tail_m;
	row_t                  mon_row;
	string                 test_name;
	int                    errors;
	int                    err_base;
	int                    checks;
	int                    tests;
	int                    seed;

	rob_tb_clk u_clk (.o_clk(clk), .o_rst_n(rst_n));

	rob_top #(.WIDTH_ROW(WROW), .WIDTH_REG(WREG), .WIDTH_BRM(WBRM)) DUT (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_dis_we(dis_we), .i_dis_pc(dis_pc), .i_dis_val(dis_val), .i_dis_op(dis_op),
		.i_dis_prd4x(dis_prd4x), .i_dis_brmask4x(dis_brmask4x),
		.i_wb_en(wb_en), .i_wb_row4x(wb_row4x), .i_wb_bank4x(wb_bank4x),
		.i_kill_en(kill_en), .i_kill_bit(kill_bit),
		.o_dis_tag(dis_tag), .o_full(full), .o_com_en(com_en), .o_com_pc(com_pc),
		.o_com_prd4x(com_prd4x), .o_com_mask(com_mask)
	);

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_pc(input pc_t exp, input pc_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: pc expected %h actual %h", test_name, exp, act);
		end
	endtask

	task automatic check_prd(input int lane, input prd_t exp, input prd_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: prd lane %0d expected %h actual %h",
				test_name, lane, exp, act);
		end
	endtask

	task automatic check_mask(input logic [NBANK-1:0] exp, input logic [NBANK-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: mask expected %b actual %b", test_name, exp, act);
		end
	endtask

	task automatic check_row(input row_t exp, input row_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: tag expected %0d actual %0d", test_name, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: %s expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	// every commit must match the oldest row in the model
	always @(negedge clk) begin
		if (rst_n && com_en) begin
			if (order_q.size() == 0) begin
				errors++;
				$display("%s: commit seen while no row was outstanding", test_name);
			end else begin
				mon_row = order_q.pop_front();
				check_pc(m_pc[mon_row], com_pc);
				for (int l = 0; l < NBANK; l++)
					check_prd(l, m_prd[mon_row][l*WREG +: WREG], com_prd4x[l*WREG +: WREG]);
				check_mask(m_mask[mon_row], com_mask);
			end
		end
	end

	function automatic logic [NBANK*WREG-1:0] rand_prd();
		return (NBANK*WREG)'({$random(seed)});
	endfunction

	task automatic dispatch(input pc_t pc, input logic [NBANK-1:0] val,
		input uop_op_e [NBANK-1:0] op, input logic [NBANK*WREG-1:0] prd4x,
		input logic [NBANK*WBRM-1:0] brm4x);
		m_pc[tail_m]   = pc;
		m_prd[tail_m]  = prd4x;
		m_brm[tail_m]  = brm4x;
		m_mask[tail_m] = val;
		for (int l = 0; l < NBANK; l++)
			m_wait[tail_m][l] = val[l] && (op[l] != OP_NOP);
		order_q.push_back(tail_m);
		dis_we       = 1'b1;
		dis_pc       = pc;
		dis_val      = val;
		dis_op       = op;
		dis_prd4x    = prd4x;
		dis_brmask4x = brm4x;
		step();
		dis_we = 1'b0;
		tail_m = tail_m + 1'b1;
	endtask

	task automatic dispatch_same(input pc_t pc, input logic [NBANK-1:0] val,
		input uop_op_e op, input logic [NBANK*WREG-1:0] prd4x,
		input logic [NBANK*WBRM-1:0] brm4x);
		uop_op_e [NBANK-1:0] ops;
		for (int l = 0; l < NBANK; l++)
			ops[l] = op;
		dispatch(pc, val, ops, prd4x, brm4x);
	endtask

	task automatic complete(input row_t r, input lane_t l, input int p);
		wb_en[p]                  = 1'b1;
		wb_row4x[p*WROW +: WROW]  = r;
		wb_bank4x[p]              = l;
		m_wait[r][l]              = 1'b0;
		step();
		wb_en = '0;
	endtask

	// all owed slots of one row in a single cycle with lane l on port l
	task automatic complete_row(input row_t r);
		for (int l = 0; l < NBANK; l++) begin
			wb_en[l]                 = m_wait[r][l];
			wb_row4x[l*WROW +: WROW] = r;
			wb_bank4x[l]             = lane_t'(l);
		end
		m_wait[r] = '0;
		step();
		wb_en = '0;
	endtask

	task automatic kill(input logic [$clog2(WBRM)-1:0] k);
		foreach (order_q[i])
			for (int l = 0; l < NBANK; l++)
				if (m_brm[order_q[i]][l*WBRM + k]) begin
					m_mask[order_q[i]][l] = 1'b0;
					m_wait[order_q[i]][l] = 1'b0;
				end
		kill_en  = 1'b1;
		kill_bit = k;
		step();
		kill_en = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (order_q.size() != 0 && n < LIMIT) begin
			step();
			n++;
		end
		if (order_q.size() != 0) begin
			errors++;
			$display("%s: timed out with %0d rows never committed",
				test_name, order_q.size());
			order_q.delete();
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_base  = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s: %s", test_name, (errors == err_base) ? "ok" : "errors");
	endtask

	task automatic reset_and_tag();
		start_test("reset_tag");
		check_flag("o_com_en", 1'b0, com_en);
		check_flag("o_full", 1'b0, full);
		check_row(row_t'(0), dis_tag);
		dispatch_same(32'h0000_1000, 4'hf, OP_ALU, rand_prd(), '0);
		step(); // row write edge updates the tag
		check_row(row_t'(0), dis_tag);
		dispatch_same(32'h0000_1004, 4'hf, OP_ALU, rand_prd(), '0);
		step();
		check_row(row_t'(1), dis_tag);
		complete_row(row_t'(0));
		complete_row(row_t'(1));
		wait_drain();
		end_test();
	endtask

	task automatic reverse_completion();
		row_t r [3];
		start_test("reverse");
		for (int i = 0; i < 3; i++) begin
			r[i] = tail_m;
			dispatch_same(32'h0000_2000 + 32'(i) * 16, NBANK'(4'hf >> i), OP_ALU,
				rand_prd(), '0);
		end
		step();
		for (int i = 2; i >= 0; i--)
			complete_row(r[i]);
		wait_drain();
		end_test();
	endtask

	task automatic nop_only_row();
		start_test("nop_row");
		dispatch_same(32'h0000_2800, 4'b0110, OP_NOP, rand_prd(), '0); // lanes 0, 3 invalid
		wait_drain();
		end_test();
	endtask

	task automatic branch_kill();
		row_t ra;
		row_t rb;
		row_t rc;
		start_test("kill");
		ra = tail_m;
		dispatch_same(32'h0000_3000, 4'hf, OP_ALU, rand_prd(), 16'h0121);
		rb = tail_m;
		dispatch_same(32'h0000_3004, 4'hf, OP_ALU, rand_prd(), 16'h0401);
		rc = tail_m;
		dispatch_same(32'h0000_3008, 4'hf, OP_BRANCH, rand_prd(), 16'h1040);
		kill(2'd0); // lands on the edge that writes rc
		complete_row(rc);
		complete_row(rb);
		complete_row(ra);
		wait_drain();
		end_test();
	endtask

	task automatic fill_and_drain();
		row_t rows [$];
		start_test("full");
		for (int i = 0; i < SIZE; i++) begin
			rows.push_back(tail_m);
			dispatch_same(32'h0000_4000 + 32'(i) * 4, 4'hf, OP_LOAD, rand_prd(), '0);
		end
		step();
		check_flag("o_full", 1'b1, full);
		foreach (rows[i])
			complete_row(rows[i]);
		wait_drain();
		check_flag("o_full", 1'b0, full);
		end_test();
	endtask

	task automatic random_bundles();
		row_t                pr [$];
		lane_t               pl [$];
		uop_op_e [NBANK-1:0] op;
		row_t                r;
		int                  idx;
		start_test("random");
		for (int b = 0; b < 10; b++) begin
			for (int n = 0; n < 4; n++) begin
				for (int l = 0; l < NBANK; l++)
					op[l] = uop_op_e'(3'({$random(seed)} % 5));
				r = tail_m;
				dispatch({$random(seed)} & 32'hffff_fffc, NBANK'({$random(seed)}), op,
					rand_prd(), '0);
				for (int l = 0; l < NBANK; l++)
					if (m_wait[r][l]) begin
						pr.push_back(r);
						pl.push_back(lane_t'(l));
					end
			end
			step();
			while (pr.size() > 0) begin
				idx = {$random(seed)} % pr.size();
				complete(pr[idx], pl[idx], {$random(seed)} % NBANK);
				pr.delete(idx);
				pl.delete(idx);
			end
			wait_drain();
		end
		end_test();
	endtask

	initial begin
		int n;
		seed     = 20;
		errors   = 0;
		err_base = 0;
		checks   = 0;
		tests    = 0;
		tail_m   = '0;
		test_name = "reset";
		dis_we       = 1'b0;
		dis_pc       = '0;
		dis_val      = '0;
		dis_prd4x    = '0;
		dis_brmask4x = '0;
		wb_en        = '0;
		wb_row4x     = '0;
		wb_bank4x    = '0;
		kill_en      = 1'b0;
		kill_bit     = '0;
		for (int l = 0; l < NBANK; l++)
			dis_op[l] = OP_NOP;
		n = 0;
		while (rst_n !== 1'b1 && n < LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			$display("reset was never released");
		end
		step();
		reset_and_tag();
		reverse_completion();
		nop_only_row();
		branch_kill();
		fill_and_drain();
		random_bundles();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
source/rob_cfg_pkg.sv
source/rob_uop_pkg.sv
source/rob_dispatch.sv
source/rob_ring_ptr.sv
source/rob_slot_bank.sv
source/rob_commit.sv
source/rob_top.sv
tb/rob_tb_clk.sv
tb/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob_retire

sources:
  - source/rob_cfg_pkg.sv
  - source/rob_uop_pkg.sv
  - source/rob_dispatch.sv
  - source/rob_ring_ptr.sv
  - source/rob_slot_bank.sv
  - source/rob_commit.sv
  - source/rob_top.sv
  - target: test
    files:
      - tb/rob_tb_clk.sv
      - tb/rob_tb.sv
